//--- filelist.f
+incdir+testbench
logic/decodePkg.sv
logic/idRegister.sv
logic/registerFile.sv
logic/instrDecoder.sv
logic/forwardSelect.sv
logic/loadHazard.sv
logic/branchTarget.sv
logic/decodeStage.sv
testbench/decodeStageTb.sv

//--- logic/branchTarget.sv
module branchTarget (
    input  decodePkg::fetchBundle idFetch,
    output logic [31:0]           jumpAddr,
    output logic [31:0]           branchAddr,
    output logic [31:0]           pcAdd8,
    output logic                  jumpPredOk,
    output logic                  pc8PredOk
);
    import decodePkg::*;

    logic [dataWidth-1:0] pcAdd4;
    logic [15:0]          offset;

    assign pcAdd4 = idFetch.pc + 32'd4;
    assign pcAdd8 = idFetch.pc + 32'd8;       // return addr / not-taken past delay slot
    assign offset = idFetch.instr.iFields.imm16;

    // 256MB region of the delay slot
    assign jumpAddr   = {pcAdd4[31:28], idFetch.instr.jFields.index26, 2'b00};
    assign branchAddr = pcAdd4 + {{14{offset[15]}}, offset, 2'b00};

    // lets EXE skip the redirect when fetch guessed right
    assign jumpPredOk = (idFetch.predTarget == jumpAddr);
    assign pc8PredOk  = (idFetch.predTarget == pcAdd8);

endmodule

//--- logic/decodePkg.sv
package decodePkg;

    localparam int dataWidth = 32;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui
    } aluOpT;

    typedef enum logic [1:0] {
        extZero,
        extSign,
        extUpper // imm16 into the high half
    } extOpT;

    typedef enum logic [1:0] {
        brNone,
        brBeq,
        brBne,
        brJump
    } branchT;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opAndi    = 6'h0C;
    localparam logic [5:0] opOri     = 6'h0D;
    localparam logic [5:0] opLui     = 6'h0F;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2B;

    // function field, SPECIAL only
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2A;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFieldsT;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iFieldsT;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] index26;
    } jFieldsT;

    // same word seen in all three encodings
    typedef union packed {
        rFieldsT rFields;
        iFieldsT iFields;
        jFieldsT jFields;
    } instrWord;

    typedef struct packed {
        logic                 valid;
        logic [dataWidth-1:0] pc;
        instrWord             instr;
        logic [dataWidth-1:0] predTarget; // fetch's guess at the next pc
    } fetchBundle;

    typedef struct packed {
        logic                 regWrite;
        logic                 isLoad;
        logic [4:0]           dst;
        logic [dataWidth-1:0] result;
    } stageWrite;

    typedef struct packed {
        aluOpT                aluOp;
        logic                 aluSrcImm;
        logic [dataWidth-1:0] imm32;
        logic [4:0]           dst;
        logic                 regWrite;
        logic                 memRead;
        logic                 memWrite;
        branchT               branch;
        logic                 isLink;
    } ctrlBundle;

    typedef struct packed {
        logic                 valid;
        logic [dataWidth-1:0] pc;
        ctrlBundle            ctrl;
        logic [dataWidth-1:0] busA;
        logic [dataWidth-1:0] busB;
        logic [dataWidth-1:0] jumpAddr;
        logic [dataWidth-1:0] branchAddr;
        logic [dataWidth-1:0] pcAdd8;
        logic                 jumpPredOk;
        logic                 pc8PredOk;
    } decodeBundle;

endpackage

//--- logic/decodeStage.sv
module decodeStage #(
    parameter int         regCount = 32,
    parameter logic [4:0] linkReg  = 5'd31
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   idFlush,
    input  logic                   idWrite,
    input  logic                   disableWrite,
    input  decodePkg::fetchBundle  fetch,
    input  decodePkg::stageWrite   exeWrite,
    input  decodePkg::stageWrite   memWrite,
    input  decodePkg::stageWrite   wbWrite,
    output decodePkg::decodeBundle decoded,
    output logic                   isBranch,
    output logic                   exeLoadStall,
    output logic                   memLoadStall
);
    import decodePkg::*;

    fetchBundle           idFetch;
    logic [dataWidth-1:0] rsData;
    logic [dataWidth-1:0] rtData;
    logic                 readsRs;
    logic                 readsRt;

    assign decoded.valid = idFetch.valid;
    assign decoded.pc    = idFetch.pc;

    idRegister uIdRegister (
        .clk     (clk),
        .reset   (reset),
        .flush   (idFlush),
        .write   (idWrite),
        .fetch   (fetch),
        .idFetch (idFetch)
    );

    registerFile #(.regCount(regCount)) uRegisterFile (
        .clk     (clk),
        .reset   (reset),
        .wbWrite (wbWrite),
        .rs      (idFetch.instr.rFields.rs),
        .rt      (idFetch.instr.rFields.rt),
        .rsData  (rsData),
        .rtData  (rtData)
    );

    instrDecoder #(.linkReg(linkReg)) uInstrDecoder (
        .idFetch      (idFetch),
        .disableWrite (disableWrite),
        .ctrl         (decoded.ctrl),
        .readsRs      (readsRs),
        .readsRt      (readsRt),
        .isBranch     (isBranch)
    );

    forwardSelect uForwardSelect (
        .rs       (idFetch.instr.rFields.rs),
        .rt       (idFetch.instr.rFields.rt),
        .rsData   (rsData),
        .rtData   (rtData),
        .exeWrite (exeWrite),
        .memWrite (memWrite),
        .wbWrite  (wbWrite),
        .busA     (decoded.busA),
        .busB     (decoded.busB)
    );

    loadHazard uLoadHazard (
        .idValid      (idFetch.valid),
        .readsRs      (readsRs),
        .readsRt      (readsRt),
        .rs           (idFetch.instr.rFields.rs),
        .rt           (idFetch.instr.rFields.rt),
        .exeWrite     (exeWrite),
        .memWrite     (memWrite),
        .exeLoadStall (exeLoadStall),
        .memLoadStall (memLoadStall)
    );

    branchTarget uBranchTarget (
        .idFetch    (idFetch),
        .jumpAddr   (decoded.jumpAddr),
        .branchAddr (decoded.branchAddr),
        .pcAdd8     (decoded.pcAdd8),
        .jumpPredOk (decoded.jumpPredOk),
        .pc8PredOk  (decoded.pc8PredOk)
    );

endmodule

//--- logic/forwardSelect.sv
module forwardSelect (
    input  logic [4:0]           rs,
    input  logic [4:0]           rt,
    input  logic [31:0]          rsData,
    input  logic [31:0]          rtData,
    input  decodePkg::stageWrite exeWrite,
    input  decodePkg::stageWrite memWrite,
    input  decodePkg::stageWrite wbWrite,
    output logic [31:0]          busA,
    output logic [31:0]          busB
);
    import decodePkg::*;

    // does this stage produce the register we want
    function automatic logic hits(input stageWrite w, input logic [4:0] src);
        return w.regWrite && (w.dst != 5'd0) && (w.dst == src);
    endfunction

    // youngest producer wins
    function automatic logic [dataWidth-1:0] pick(
        input logic [4:0]           src,
        input logic [dataWidth-1:0] rfData
    );
        if (hits(exeWrite, src)) begin
            return exeWrite.result;
        end else if (hits(memWrite, src)) begin
            return memWrite.result;
        end else if (hits(wbWrite, src)) begin
            return wbWrite.result;  // covers the write-then-read same cycle
        end
        return rfData;
    endfunction

    assign busA = pick(rs, rsData);
    assign busB = pick(rt, rtData);

endmodule

//--- logic/idRegister.sv
module idRegister (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   write,
    input  decodePkg::fetchBundle  fetch,
    output decodePkg::fetchBundle  idFetch
);

    // flush clears only valid and the instr word
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            idFetch.valid <= 1'b0;
            idFetch.instr <= '0;         // a bubble decodes as sll $0
        end else if (write) begin
            idFetch <= fetch;
        end
    end

endmodule

//--- logic/instrDecoder.sv
module instrDecoder #(
    parameter logic [4:0] linkReg = 5'd31
) (
    input  decodePkg::fetchBundle idFetch,
    input  logic                  disableWrite,
    output decodePkg::ctrlBundle  ctrl,
    output logic                  readsRs,
    output logic                  readsRt,
    output logic                  isBranch
);
    import decodePkg::*;

    ctrlBundle raw;
    extOpT     extOp;
    logic      functOk;
    logic [15:0] imm16;

    assign imm16 = idFetch.instr.iFields.imm16;

    always_comb begin
        raw     = '0;
        extOp   = extZero;
        functOk = 1'b0;
        readsRs = 1'b0;
        readsRt = 1'b0;
        case (idFetch.instr.rFields.op)
            opSpecial: begin
                functOk = 1'b1;
                case (idFetch.instr.rFields.funct)
                    fnAddu:  raw.aluOp = aluAdd;
                    fnSubu:  raw.aluOp = aluSub;
                    fnAnd:   raw.aluOp = aluAnd;
                    fnOr:    raw.aluOp = aluOr;
                    fnSlt:   raw.aluOp = aluSlt;
                    default: functOk   = 1'b0;   // unsupported funct is a nop
                endcase
                raw.regWrite = functOk;
                raw.dst      = functOk ? idFetch.instr.rFields.rd : 5'd0;
                readsRs      = functOk;
                readsRt      = functOk;
            end
            opAddiu, opAndi, opOri, opLui, opLw: begin
                raw.aluSrcImm = 1'b1;
                raw.regWrite  = 1'b1;
                raw.dst       = idFetch.instr.iFields.rt;
                readsRs       = (idFetch.instr.iFields.op != opLui);
                case (idFetch.instr.iFields.op)
                    opAndi:  begin raw.aluOp = aluAnd; extOp = extZero;  end
                    opOri:   begin raw.aluOp = aluOr;  extOp = extZero;  end
                    opLui:   begin raw.aluOp = aluLui; extOp = extUpper; end
                    default: begin raw.aluOp = aluAdd; extOp = extSign;  end
                endcase
                raw.memRead = (idFetch.instr.iFields.op == opLw);
            end
            opSw: begin
                raw.aluOp     = aluAdd;
                raw.aluSrcImm = 1'b1;
                raw.memWrite  = 1'b1;
                extOp         = extSign;
                readsRs       = 1'b1;
                readsRt       = 1'b1;      // store data
            end
            opBeq, opBne: begin
                raw.aluOp  = aluSub;
                raw.branch = (idFetch.instr.iFields.op == opBeq) ? brBeq : brBne;
                extOp      = extSign;
                readsRs    = 1'b1;
                readsRt    = 1'b1;
            end
            opJ: raw.branch = brJump;
            opJal: begin
                raw.branch   = brJump;
                raw.isLink   = 1'b1;
                raw.regWrite = 1'b1;
                raw.dst      = linkReg;  // return address in $ra
            end
            default: ;                   // unknown opcode, all zero
        endcase

        case (extOp)
            extSign:  raw.imm32 = {{16{imm16[15]}}, imm16};
            extUpper: raw.imm32 = {imm16, 16'h0000};
            default:  raw.imm32 = {16'h0000, imm16};
        endcase
    end

    // invalid kills everything, disableWrite only the state-changing parts
    always_comb begin
        ctrl = raw;
        if (!idFetch.valid) begin
            ctrl.regWrite = 1'b0;
            ctrl.memRead  = 1'b0;
            ctrl.memWrite = 1'b0;
            ctrl.branch   = brNone;
            ctrl.isLink   = 1'b0;
        end else if (disableWrite) begin
            ctrl.regWrite = 1'b0;
            ctrl.memRead  = 1'b0;
            ctrl.memWrite = 1'b0;
        end
    end

    assign isBranch = (ctrl.branch != brNone);

endmodule

//--- logic/loadHazard.sv
module loadHazard (
    input  logic                 idValid,
    input  logic                 readsRs,
    input  logic                 readsRt,
    input  logic [4:0]           rs,
    input  logic [4:0]           rt,
    input  decodePkg::stageWrite exeWrite,
    input  decodePkg::stageWrite memWrite,
    output logic                 exeLoadStall,
    output logic                 memLoadStall
);
    import decodePkg::*;

    // load data not ready yet, so forwarding can't help
    function automatic logic loadHit(input stageWrite w);
        logic srcMatch;
        srcMatch = (readsRs && w.dst == rs) || (readsRt && w.dst == rt);
        return idValid && w.regWrite && w.isLoad && (w.dst != 5'd0) && srcMatch;
    endfunction

    assign exeLoadStall = loadHit(exeWrite);
    assign memLoadStall = loadHit(memWrite);

endmodule

//--- logic/registerFile.sv
module registerFile #(
    parameter int regCount = 32
) (
    input  logic                 clk,
    input  logic                 reset,
    input  decodePkg::stageWrite wbWrite,
    input  logic [4:0]           rs,
    input  logic [4:0]           rt,
    output logic [31:0]          rsData,
    output logic [31:0]          rtData
);
    import decodePkg::*;

    logic [dataWidth-1:0] regs [1:regCount-1]; // $zero has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWrite.regWrite && wbWrite.dst != 5'd0) begin
            regs[wbWrite.dst] <= wbWrite.result;
        end
    end

    // same-cycle WB data comes in through the bypass, not here
    assign rsData = (rs == 5'd0) ? '0 : regs[rs];
    assign rtData = (rt == 5'd0) ? '0 : regs[rt];

endmodule

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module decodeStageTb \
    -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/VdecodeStageTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- testbench/decodeModel.svh
`ifndef decodeModelSvh
`define decodeModelSvh

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic knownFunct(input logic [5:0] fn);
    return fn inside {fnAddu, fnSubu, fnAnd, fnOr, fnSlt};
endfunction

// expected control word, built from the raw instruction bits
function automatic ctrlBundle modelCtrl(input fetchBundle f, input logic noWrite);
    ctrlBundle   c;
    logic [31:0] w;
    logic [5:0]  op;
    logic [15:0] imm;
    w   = f.instr;
    op  = w[31:26];
    imm = w[15:0];
    c   = '0;
    c.imm32 = {16'h0000, imm};            // zero extension by default
    case (op)
        opSpecial: begin
            c.regWrite = knownFunct(w[5:0]);
            c.dst      = c.regWrite ? w[15:11] : 5'd0;
            case (w[5:0])
                fnSubu:  c.aluOp = aluSub;
                fnAnd:   c.aluOp = aluAnd;
                fnOr:    c.aluOp = aluOr;
                fnSlt:   c.aluOp = aluSlt;
                default: c.aluOp = aluAdd;
            endcase
        end
        opAddiu, opLw, opSw: begin
            c.aluSrcImm = 1'b1;
            c.imm32     = {{16{imm[15]}}, imm};
            c.regWrite  = (op != opSw);
            c.dst       = (op != opSw) ? w[20:16] : 5'd0;
            c.memRead   = (op == opLw);
            c.memWrite  = (op == opSw);
        end
        opAndi, opOri, opLui: begin
            c.aluSrcImm = 1'b1;
            c.regWrite  = 1'b1;
            c.dst       = w[20:16];
            c.aluOp     = (op == opAndi) ? aluAnd : (op == opOri) ? aluOr : aluLui;
            if (op == opLui) begin
                c.imm32 = {imm, 16'h0000};
            end
        end
        opBeq, opBne: begin
            c.aluOp  = aluSub;
            c.imm32  = {{16{imm[15]}}, imm};
            c.branch = (op == opBeq) ? brBeq : brBne;
        end
        opJ, opJal: begin
            c.branch   = brJump;
            c.isLink   = (op == opJal);
            c.regWrite = (op == opJal);
            c.dst      = (op == opJal) ? 5'd31 : 5'd0;
        end
        default: ;
    endcase
    if (!f.valid) begin
        c.regWrite = 1'b0;
        c.memRead  = 1'b0;
        c.memWrite = 1'b0;
        c.branch   = brNone;
        c.isLink   = 1'b0;
    end else if (noWrite) begin
        c.regWrite = 1'b0;
        c.memRead  = 1'b0;
        c.memWrite = 1'b0;
    end
    return c;
endfunction

// {reads rs, reads rt}
function automatic logic [1:0] modelReads(input logic [31:0] w);
    case (w[31:26])
        opSpecial:                    return knownFunct(w[5:0]) ? 2'b11 : 2'b00;
        opAddiu, opLw, opAndi, opOri: return 2'b10;
        opSw, opBeq, opBne:           return 2'b11;
        default:                      return 2'b00;
    endcase
endfunction

`endif

//--- testbench/decodeStageTb.sv
module decodeStageTb;
    import decodePkg::*;

    `include "decodeModel.svh"

    logic        clk;
    logic        reset;
    logic        idFlush;
    logic        idWrite;
    logic        disableWrite;
    fetchBundle  fetch;
    stageWrite   exeWrite;
    stageWrite   memWrite;
    stageWrite   wbWrite;
    decodeBundle decoded;
    logic        isBranch;
    logic        exeLoadStall;
    logic        memLoadStall;

    logic [31:0] lfsrState = 32'd69716;
    logic [31:0] shadow [0:31];   // expected register file contents
    fetchBundle  expFetch;        // expected IF/ID contents
    logic        pcLoaded = 1'b0; // pc is unknown until the first load
    int          checkCount = 0;
    int          errorCount = 0;
    int          timeoutCount = 0;
    logic [5:0]  opPool [0:15];
    logic [5:0]  fnPool [0:7];

    decodeStage uut (
        .clk          (clk),
        .reset        (reset),
        .idFlush      (idFlush),
        .idWrite      (idWrite),
        .disableWrite (disableWrite),
        .fetch        (fetch),
        .exeWrite     (exeWrite),
        .memWrite     (memWrite),
        .wbWrite      (wbWrite),
        .decoded      (decoded),
        .isBranch     (isBranch),
        .exeLoadStall (exeLoadStall),
        .memLoadStall (memLoadStall)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
        end else if (wbWrite.regWrite && wbWrite.dst != 5'd0) begin
            shadow[wbWrite.dst] <= wbWrite.result;
        end
        if (reset || idFlush) begin
            expFetch.valid <= 1'b0;   // flush beats write
            expFetch.instr <= '0;
        end else if (idWrite) begin
            expFetch <= fetch;
            pcLoaded <= 1'b1;
        end
    end

    // youngest producer first, $zero never forwarded
    function automatic logic [31:0] expectBus(input logic [4:0] src);
        if (src == 5'd0) return '0;
        if (exeWrite.regWrite && exeWrite.dst == src) return exeWrite.result;
        if (memWrite.regWrite && memWrite.dst == src) return memWrite.result;
        if (wbWrite.regWrite && wbWrite.dst == src) return wbWrite.result;
        return shadow[src];
    endfunction

    function automatic logic expectStall(input stageWrite w, input logic [1:0] reads,
                                         input logic [31:0] word);
        logic uses;
        uses = (reads[1] && w.dst == word[25:21]) || (reads[0] && w.dst == word[20:16]);
        return expFetch.valid && w.regWrite && w.isLoad && w.dst != 5'd0 && uses;
    endfunction

    task automatic flagMismatch(input string what, input logic [63:0] got,
                                input logic [63:0] exp);
        errorCount++;
        $display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, exp);
    endtask

    task automatic checkOutputs();
        ctrlBundle   ce;
        logic [31:0] word;
        logic [1:0]  reads;
        logic [31:0] pc4;
        logic [31:0] jumpExp;
        logic [31:0] sext;
        word  = expFetch.instr;
        ce    = modelCtrl(expFetch, disableWrite);
        reads = modelReads(word);
        checkCount++;
        assert (decoded.valid === expFetch.valid)
            else flagMismatch("valid", 64'(decoded.valid), 64'(expFetch.valid));
        assert (decoded.ctrl === ce) else flagMismatch("ctrl", 64'(decoded.ctrl), 64'(ce));
        assert (isBranch === (ce.branch != brNone))
            else flagMismatch("isBranch", 64'(isBranch), 64'(ce.branch != brNone));
        assert (decoded.busA === expectBus(word[25:21]))
            else flagMismatch("busA", 64'(decoded.busA), 64'(expectBus(word[25:21])));
        assert (decoded.busB === expectBus(word[20:16]))
            else flagMismatch("busB", 64'(decoded.busB), 64'(expectBus(word[20:16])));
        assert (exeLoadStall === expectStall(exeWrite, reads, word))
            else flagMismatch("exeLoadStall", 64'(exeLoadStall), 64'(!exeLoadStall));
        assert (memLoadStall === expectStall(memWrite, reads, word))
            else flagMismatch("memLoadStall", 64'(memLoadStall), 64'(!memLoadStall));
        if (pcLoaded) begin
            pc4     = expFetch.pc + 32'd4;
            jumpExp = {pc4[31:28], word[25:0], 2'b00};
            sext    = {{16{word[15]}}, word[15:0]};
            assert (decoded.pc === expFetch.pc)
                else flagMismatch("pc", 64'(decoded.pc), 64'(expFetch.pc));
            assert (decoded.jumpAddr === jumpExp)
                else flagMismatch("jumpAddr", 64'(decoded.jumpAddr), 64'(jumpExp));
            assert (decoded.branchAddr === pc4 + (sext << 2))
                else flagMismatch("branchAddr", 64'(decoded.branchAddr), 64'(pc4 + (sext << 2)));
            assert (decoded.pcAdd8 === expFetch.pc + 32'd8)
                else flagMismatch("pcAdd8", 64'(decoded.pcAdd8), 64'(expFetch.pc + 32'd8));
            assert (decoded.jumpPredOk === (expFetch.predTarget == jumpExp))
                else flagMismatch("jumpPredOk", 64'(decoded.jumpPredOk), 64'(!decoded.jumpPredOk));
            assert (decoded.pc8PredOk === (expFetch.predTarget == expFetch.pc + 32'd8))
                else flagMismatch("pc8PredOk", 64'(decoded.pc8PredOk), 64'(!decoded.pc8PredOk));
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            checkOutputs();
        end
    end

    function automatic stageWrite randomWrite();
        stageWrite w;
        w.regWrite = 1'(takeBits(1));
        w.isLoad   = 1'(takeBits(1));
        w.dst      = 5'(takeBits(3));   // few registers so sources collide often
        w.result   = takeBits(32);
        return w;
    endfunction

    task automatic driveRandom();
        fetchBundle  f;
        logic [31:0] word;
        logic [31:0] pc4;
        word        = takeBits(32);
        word[31:26] = opPool[4'(takeBits(4))];
        word[25:21] = 5'(takeBits(3));
        word[20:16] = 5'(takeBits(3));
        word[15:11] = 5'(takeBits(3));
        if (word[31:26] == opSpecial) begin
            word[5:0] = fnPool[3'(takeBits(3))];
        end
        f.valid = (takeBits(3) != 32'd0);
        f.pc    = {30'(takeBits(30)), 2'b00};
        f.instr = word;
        pc4     = f.pc + 32'd4;
        case (2'(takeBits(2)))
            2'd0:    f.predTarget = {pc4[31:28], word[25:0], 2'b00};
            2'd1:    f.predTarget = f.pc + 32'd8;
            default: f.predTarget = takeBits(32);
        endcase
        fetch        <= f;
        exeWrite     <= randomWrite();
        memWrite     <= randomWrite();
        wbWrite      <= randomWrite();
        idWrite      <= (takeBits(3) != 32'd0);
        idFlush      <= (takeBits(4) == 32'd0);
        disableWrite <= (takeBits(4) == 32'd0);
    endtask

    task automatic awaitStall(input logic fromMem);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!(fromMem ? memLoadStall : exeLoadStall) && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (!(fromMem ? memLoadStall : exeLoadStall)) begin
            timeoutCount++;
            $display("timeout: the %s load stall never rose within 10 cycles",
                     fromMem ? "MEM" : "EXE");
        end
    endtask

    // addu $11, $9, $10 behind a load in EXE, then in MEM
    task automatic loadUsePhase();
        fetchBundle f;
        f.valid      = 1'b1;
        f.pc         = 32'h0040_0100;
        f.instr      = {opSpecial, 5'd9, 5'd10, 5'd11, 5'd0, fnAddu};
        f.predTarget = 32'h0040_0108;
        @(posedge clk);
        fetch        <= f;
        idWrite      <= 1'b1;
        idFlush      <= 1'b0;
        disableWrite <= 1'b0;
        exeWrite     <= '{regWrite: 1'b1, isLoad: 1'b1, dst: 5'd10, result: 32'h1234_5678};
        memWrite     <= '0;
        wbWrite      <= '0;
        awaitStall(1'b0);
        @(posedge clk);
        idWrite  <= 1'b0;            // ID holds while stalled
        exeWrite <= '0;
        memWrite <= '{regWrite: 1'b1, isLoad: 1'b1, dst: 5'd9, result: 32'h0BAD_F00D};
        awaitStall(1'b1);
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        idFlush      = 1'b0;
        idWrite      = 1'b0;
        disableWrite = 1'b0;
        fetch        = '0;
        exeWrite     = '0;
        memWrite     = '0;
        wbWrite      = '0;
        opPool = '{opSpecial, opSpecial, opJ, opJal, opBeq, opBne, opAddiu, opAndi,
                   opOri, opLui, opLw, opSw, opSpecial, 6'h08, 6'h20, 6'h3F};
        fnPool = '{fnAddu, fnSubu, fnAnd, fnOr, fnSlt, 6'h20, 6'h00, 6'h08};
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        repeat (3) @(posedge clk);   // idle controls after reset
        for (int n = 0; n < 600; n++) begin
            @(posedge clk);
            driveRandom();
        end
        loadUsePhase();
        for (int n = 0; n < 200; n++) begin
            @(posedge clk);
            driveRandom();
        end
        @(posedge clk);
        @(negedge clk);
        $display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
